// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_block_merger
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/bitonic_merge8.sv
`timescale 1ns/1ns
`include "merge_macros.svh"

module bitonic_merge8 import merge_pkg::*; (
   input  blk_t i_x,
   input  blk_t i_y,
   output blk_t o_lo,
   output blk_t o_hi
);

   localparam int N = 2 * `MRG_RECS;
   localparam int LV = $clog2(N);

   rec_t st [LV+1][N];

   // on equal keys the lower position keeps its record
   function automatic rec_t min_rec(input rec_t a, input rec_t b);
      return (b.key < a.key) ? b : a;
   endfunction

   function automatic rec_t max_rec(input rec_t a, input rec_t b);
      return (b.key < a.key) ? a : b;
   endfunction

   always_comb begin
      int d;
      int p;
      // x ascending followed by y reversed gives one bitonic sequence
      for (int j = 0; j < `MRG_RECS; j++) begin
         st[0][j] = i_x[j];
         st[0][N-1-j] = i_y[j];
      end
      // half cleaners with distance N/2, then N/4, down to 1
      for (int lv = 0; lv < LV; lv++) begin
         d = (N / 2) >> lv;
         for (int j = 0; j < N; j++) begin
            p = j ^ d;
            if ((j & d) == 0) begin
               st[lv+1][j] = min_rec(st[lv][j], st[lv][p]);
            end else begin
               st[lv+1][j] = max_rec(st[lv][p], st[lv][j]);
            end
         end
      end
   end

   always_comb begin
      for (int j = 0; j < `MRG_RECS; j++) begin
         o_lo[j] = st[LV][j];
         o_hi[j] = st[LV][`MRG_RECS+j];
      end
   end

endmodule

// File: hw/block_fifo.sv
`timescale 1ns/1ns
`include "merge_macros.svh"

module block_fifo import merge_pkg::*; (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_wr,
   input  blk_t i_data,
   input  logic i_rd,
   output blk_t o_head,
   output logic o_empty,
   output logic o_full
);

   localparam int AW = $clog2(`MRG_FIFO_DEPTH);

   blk_t mem [`MRG_FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0] count;

   always_ff @(posedge i_clk) begin
      if (i_wr) begin
         mem[wr_ptr] <= i_data;
      end
   end

   // the depth is a power of two so the pointers wrap on their own
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (i_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (i_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (i_wr && !i_rd) begin
            count <= count + 1'b1;
         end else if (i_rd && !i_wr) begin
            count <= count - 1'b1;
         end
      end
   end

   // the controller looks at the head before deciding to pop it
   assign o_head = mem[rd_ptr];
   assign o_empty = (count == '0);
   assign o_full = (count == (AW+1)'(`MRG_FIFO_DEPTH));

endmodule

// File: hw/block_merger.sv
`timescale 1ns/1ns
`include "merge_macros.svh"

module block_merger import merge_pkg::*; (
   input  logic i_clk,
   input  logic i_rst,
   input  blk_in_t i_a,
   input  blk_in_t i_b,
   output blk_out_t o_out
);

   blk_t head_a;
   blk_t head_b;
   blk_t head_sel;
   logic empty_a;
   logic empty_b;
   logic full_a;
   logic full_b;
   logic wr_a;
   logic wr_b;
   logic pop_a;
   logic pop_b;
   logic sel_b;
   logic load_top;
   logic merge_en;
   logic emit_top;
   logic emit_mark;
   logic clr_count;
   blk_t net_lo;
   blk_t net_hi;
   blk_t top_q;
   logic [`MRG_CNT_W-1:0] count;
   logic out_valid;
   blk_u out_blk;

   // a strobe into a full FIFO is dropped, the caller broke the contract
   assign wr_a = i_a.valid && !full_a;
   assign wr_b = i_b.valid && !full_b;

   block_fifo fifo_a (
      .i_clk(i_clk), .i_rst(i_rst), .i_wr(wr_a), .i_data(i_a.blk), .i_rd(pop_a),
      .o_head(head_a), .o_empty(empty_a), .o_full(full_a)
   );

   block_fifo fifo_b (
      .i_clk(i_clk), .i_rst(i_rst), .i_wr(wr_b), .i_data(i_b.blk), .i_rd(pop_b),
      .o_head(head_b), .o_empty(empty_b), .o_full(full_b)
   );

   merge_ctrl ctrl0 (
      .i_clk(i_clk), .i_rst(i_rst),
      .i_head_a(head_a), .i_head_b(head_b), .i_empty_a(empty_a), .i_empty_b(empty_b),
      .o_pop_a(pop_a), .o_pop_b(pop_b), .o_sel_b(sel_b), .o_load_top(load_top),
      .o_merge_en(merge_en), .o_emit_top(emit_top), .o_emit_mark(emit_mark),
      .o_clr_count(clr_count)
   );

   assign head_sel = sel_b ? head_b : head_a;

   bitonic_merge8 net0 (
      .i_x(top_q), .i_y(head_sel), .o_lo(net_lo), .o_hi(net_hi)
   );

   run_counter cnt0 (
      .i_clk(i_clk), .i_rst(i_rst), .i_inc(merge_en || emit_top), .i_clr(clr_count),
      .o_count(count)
   );

   // top always holds the four largest records seen so far in the run
   always_ff @(posedge i_clk) begin
      if (load_top) begin
         top_q <= head_sel;
      end else if (merge_en) begin
         top_q <= net_hi;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= merge_en || emit_top || emit_mark;
      end
   end

   always_ff @(posedge i_clk) begin
      if (merge_en) begin
         out_blk.recs <= net_lo;
      end else if (emit_top) begin
         out_blk.recs <= top_q;
      end else if (emit_mark) begin
         out_blk.mark.pad <= '0;
         out_blk.mark.blocks <= count;
      end
   end

   assign o_out.valid = out_valid;
   assign o_out.blk = out_blk;

endmodule

// File: hw/merge_ctrl.sv
`timescale 1ns/1ns
`include "merge_macros.svh"

module merge_ctrl import merge_pkg::*; (
   input  logic i_clk,
   input  logic i_rst,
   input  blk_t i_head_a,
   input  blk_t i_head_b,
   input  logic i_empty_a,
   input  logic i_empty_b,
   output logic o_pop_a,
   output logic o_pop_b,
   output logic o_sel_b,
   output logic o_load_top,
   output logic o_merge_en,
   output logic o_emit_top,
   output logic o_emit_mark,
   output logic o_clr_count
);

   mrg_state_e state;
   mrg_state_e state_nxt;
   logic [`MRG_KEY_W-1:0] key_a;
   logic [`MRG_KEY_W-1:0] key_b;
   logic term_a;
   logic term_b;
   logic both;
   logic b_first;

   // only record 0 matters, it is the smallest key of a block
   assign key_a = i_head_a[0].key;
   assign key_b = i_head_b[0].key;
   assign term_a = (key_a == '0);
   assign term_b = (key_b == '0);
   assign both = !i_empty_a && !i_empty_b;
   assign b_first = (key_b < key_a);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state <= PRIME;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      o_pop_a = 1'b0;
      o_pop_b = 1'b0;
      o_sel_b = 1'b0;
      o_load_top = 1'b0;
      o_merge_en = 1'b0;
      o_emit_top = 1'b0;
      o_emit_mark = 1'b0;
      o_clr_count = 1'b0;
      case (state)
         PRIME: begin
            // a run holds at least one data block, so neither head ends it here
            if (both) begin
               o_sel_b = b_first;
               o_pop_a = !b_first;
               o_pop_b = b_first;
               o_load_top = 1'b1;
               state_nxt = MERGE;
            end
         end
         MERGE: begin
            if (both) begin
               if (term_a) begin
                  o_pop_a = 1'b1;
                  state_nxt = DRAIN_B;
               end else if (term_b) begin
                  o_sel_b = 1'b1;
                  o_pop_b = 1'b1;
                  state_nxt = DRAIN_A;
               end else begin
                  o_sel_b = b_first;
                  o_pop_a = !b_first;
                  o_pop_b = b_first;
                  o_merge_en = 1'b1;
               end
            end
         end
         DRAIN_A: begin
            if (!i_empty_a) begin
               o_pop_a = 1'b1;
               o_merge_en = !term_a;
               state_nxt = term_a ? FLUSH : DRAIN_A;
            end
         end
         DRAIN_B: begin
            if (!i_empty_b) begin
               o_sel_b = 1'b1;
               o_pop_b = 1'b1;
               o_merge_en = !term_b;
               state_nxt = term_b ? FLUSH : DRAIN_B;
            end
         end
         FLUSH: begin
            o_emit_top = 1'b1;
            state_nxt = MARK;
         end
         MARK: begin
            o_emit_mark = 1'b1;
            o_clr_count = 1'b1;
            state_nxt = PRIME;
         end
         default: begin
            state_nxt = PRIME;
         end
      endcase
   end

endmodule

// File: hw/merge_macros.svh
`ifndef MERGE_MACROS_SVH
`define MERGE_MACROS_SVH

// key zero never appears in data, it marks the end of a run
`define MRG_KEY_W 8
`define MRG_VAL_W 8

// records per block, the network merges two blocks of this size
`define MRG_RECS 4

`define MRG_CNT_W 8
`define MRG_FIFO_DEPTH 8

`endif

// File: hw/merge_pkg.sv
`include "merge_macros.svh"

package merge_pkg;

   typedef struct packed {
      logic [`MRG_KEY_W-1:0] key;
      logic [`MRG_VAL_W-1:0] val;
   } rec_t;

   // element 0 sits in the low bits and carries the smallest key
   typedef rec_t [`MRG_RECS-1:0] blk_t;

   // blocks lands on the value field of record 0 and the zero pad
   // covers record 0's key, so a marker also reads as a terminator
   typedef struct packed {
      logic [`MRG_RECS*(`MRG_KEY_W+`MRG_VAL_W)-`MRG_CNT_W-1:0] pad;
      logic [`MRG_CNT_W-1:0] blocks;
   } mark_t;

   typedef union packed {
      blk_t recs;
      mark_t mark;
   } blk_u;

   typedef struct packed {
      logic valid;
      blk_t blk;
   } blk_in_t;

   typedef struct packed {
      logic valid;
      blk_u blk;
   } blk_out_t;

   typedef enum logic [2:0] {
      PRIME,
      MERGE,
      DRAIN_A,
      DRAIN_B,
      FLUSH,
      MARK
   } mrg_state_e;

endpackage

// File: hw/run_counter.sv
`timescale 1ns/1ns
`include "merge_macros.svh"

module run_counter (
   input  logic i_clk,
   input  logic i_rst,
   input  logic i_inc,
   input  logic i_clr,
   output logic [`MRG_CNT_W-1:0] o_count
);

   logic [`MRG_CNT_W-1:0] count;

   // clear wins, the marker cycle never emits a data block anyway
   always_ff @(posedge i_clk) begin
      if (i_rst || i_clr) begin
         count <= '0;
      end else if (i_inc) begin
         count <= count + 1'b1;
      end
   end

   assign o_count = count;

endmodule

// File: sources.f
+incdir+hw
hw/merge_pkg.sv
hw/block_fifo.sv
hw/bitonic_merge8.sv
hw/run_counter.sv
hw/merge_ctrl.sv
hw/block_merger.sv
test/block_merger_asserts.sv
test/tb_block_merger.sv

// File: test/block_merger_asserts.sv
`timescale 1ns/1ns
`include "merge_macros.svh"

module block_merger_asserts import merge_pkg::*; (
   input logic i_clk,
   input logic i_rst,
   input blk_in_t i_a,
   input blk_in_t i_b,
   input logic i_full_a,
   input logic i_full_b,
   input logic i_pop_a,
   input logic i_pop_b,
   input blk_out_t i_out
);

   function automatic logic keys_ascending(input blk_t b);
      logic ok;
      ok = 1'b1;
      for (int r = 1; r < `MRG_RECS; r++) begin
         if (b[r].key < b[r-1].key) begin
            ok = 1'b0;
         end
      end
      return ok;
   endfunction

   a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_a.valid && i_full_a) && !(i_b.valid && i_full_b))
      else $error("input block written while its FIFO is full");

   // a marker has key zero in record 0, anything else is a data block
   a_sorted_out: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_out.valid && i_out.blk.recs[0].key != '0) |-> keys_ascending(i_out.blk.recs))
      else $error("output data block keys are not ascending");

   a_quiet_reset: assert property (@(posedge i_clk) i_rst |=> !i_out.valid)
      else $error("output strobe seen during reset");

   a_one_pop: assert property (@(posedge i_clk) disable iff (i_rst) !(i_pop_a && i_pop_b))
      else $error("both FIFOs popped in the same cycle");

endmodule

bind block_merger block_merger_asserts asrt0 (
   .i_clk(i_clk), .i_rst(i_rst), .i_a(i_a), .i_b(i_b),
   .i_full_a(full_a), .i_full_b(full_b), .i_pop_a(pop_a), .i_pop_b(pop_b),
   .i_out(o_out)
);

// File: test/tb_block_merger.sv
`timescale 1ns/1ns
`include "merge_macros.svh"

module tb_block_merger import merge_pkg::*; ();

   logic i_clk;
   logic i_rst;
   blk_in_t i_a;
   blk_in_t i_b;
   blk_out_t o_out;

   logic [31:0] lfsr_q = 32'hfbbd8047;
   blk_t q_a [$];
   blk_t q_b [$];
   blk_u exp_q [$];
   blk_u got_q [$];
   int exp_marks = 0;
   int marks_seen = 0;
   int checked = 0;
   int blocks_sent = 0;
   int cycle_cnt;

   block_merger dut0 (
      .i_clk(i_clk), .i_rst(i_rst), .i_a(i_a), .i_b(i_b), .o_out(o_out)
   );

   initial i_clk = 1'b0;
   always #2 i_clk = ~i_clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h80200003;
      end
      return s >> 1;
   endfunction

   function automatic int rand_bits(input int n);
      int r;
      r = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         r = (r << 1) | {31'b0, lfsr_q[0]};
      end
      return r;
   endfunction

   function automatic blk_t blk_at(input rec_t list [$], input int j);
      blk_t b;
      for (int r = 0; r < `MRG_RECS; r++) begin
         b[r] = list[`MRG_RECS*j + r];
      end
      return b;
   endfunction

   // only record 0's key marks the end, the rest of the block is noise
   function automatic blk_t make_term();
      blk_t t;
      t = {rand_bits(32), rand_bits(32)};
      t[0].key = '0;
      return t;
   endfunction

   task automatic value_fail(input string name, input logic [63:0] exp, input logic [63:0] got);
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
   endtask

   // picks distinct keys, splits them over the streams and queues the blocks
   // mode 1 puts the low keys on stream A, mode 2 on stream B
   task automatic prepare_run(input int na, input int nb, input int mode);
      int owner [256];
      rec_t list_a [$];
      rec_t list_b [$];
      rec_t list_all [$];
      rec_t rec;
      blk_u mark;
      logic to_b;
      int picked;
      int idx;
      int k;
      int rem_a;
      int rem_b;
      int nblk;
      foreach (owner[i]) begin
         owner[i] = 0;
      end
      picked = 0;
      while (picked < `MRG_RECS * (na + nb)) begin
         k = rand_bits(8);
         if (k != 0 && owner[k] == 0) begin
            owner[k] = 1;
            picked++;
         end
      end
      idx = 0;
      rem_a = `MRG_RECS * na;
      rem_b = `MRG_RECS * nb;
      for (int key = 1; key < 256; key++) begin
         if (owner[key] != 0) begin
            case (mode)
               1: to_b = (idx >= `MRG_RECS * na);
               2: to_b = (idx < `MRG_RECS * nb);
               default: to_b = (rem_a == 0) || (rem_b != 0 && rand_bits(1) == 1);
            endcase
            rec.key = key[`MRG_KEY_W-1:0];
            k = rand_bits(`MRG_VAL_W);
            rec.val = k[`MRG_VAL_W-1:0];
            if (to_b) begin
               list_b.push_back(rec);
               rem_b--;
            end else begin
               list_a.push_back(rec);
               rem_a--;
            end
            list_all.push_back(rec);
            idx++;
         end
      end
      for (int j = 0; j < na; j++) begin
         q_a.push_back(blk_at(list_a, j));
      end
      q_a.push_back(make_term());
      for (int j = 0; j < nb; j++) begin
         q_b.push_back(blk_at(list_b, j));
      end
      q_b.push_back(make_term());
      // the merged run is the sorted union cut into blocks, then the marker
      for (int j = 0; j < na + nb; j++) begin
         exp_q.push_back(blk_at(list_all, j));
      end
      nblk = na + nb;
      mark = '0;
      mark.mark.blocks = nblk[`MRG_CNT_W-1:0];
      exp_q.push_back(mark);
      exp_marks++;
   endtask

   task automatic send_blocks();
      int gap_a;
      int gap_b;
      gap_a = rand_bits(2);
      gap_b = rand_bits(2);
      while (q_a.size() > 0 || q_b.size() > 0) begin
         @(negedge i_clk);
         i_a.valid = 1'b0;
         i_b.valid = 1'b0;
         if (q_a.size() > 0) begin
            if (gap_a == 0) begin
               i_a.valid = 1'b1;
               i_a.blk = q_a.pop_front();
               blocks_sent++;
               gap_a = rand_bits(2);
            end else begin
               gap_a--;
            end
         end
         if (q_b.size() > 0) begin
            if (gap_b == 0) begin
               i_b.valid = 1'b1;
               i_b.blk = q_b.pop_front();
               blocks_sent++;
               gap_b = rand_bits(2);
            end else begin
               gap_b--;
            end
         end
      end
      @(negedge i_clk);
      i_a.valid = 1'b0;
      i_b.valid = 1'b0;
   endtask

   task automatic wait_marks();
      while (marks_seen < exp_marks) begin
         @(posedge i_clk);
      end
   endtask

   task automatic check_results(input string name);
      assert (got_q.size() == exp_q.size())
         else value_fail({name, " o_out strobe count"}, 64'(exp_q.size()), 64'(got_q.size()));
      for (int i = checked; i < exp_q.size(); i++) begin
         assert (got_q[i] == exp_q[i])
            else value_fail($sformatf("%s o_out.blk[%0d]", name, i), exp_q[i], got_q[i]);
      end
      checked = exp_q.size();
   endtask

   task automatic run_case(input int na, input int nb, input int mode);
      prepare_run(na, nb, mode);
      send_blocks();
      wait_marks();
   endtask

   task automatic test_single_blocks();
      run_case(1, 1, 0);
      check_results("single blocks");
   endtask

   task automatic test_interleaved();
      run_case(2, 5, 0);
      run_case(4, 1, 0);
      check_results("interleaved");
   endtask

   task automatic test_drain_paths();
      run_case(3, 2, 1);
      check_results("drain b");
      run_case(2, 3, 2);
      check_results("drain a");
   endtask

   // the second run is queued behind the first terminators
   task automatic test_back_to_back();
      prepare_run(2, 2, 0);
      prepare_run(3, 1, 0);
      send_blocks();
      wait_marks();
      check_results("back to back");
   endtask

   task automatic test_random_runs();
      int na;
      int nb;
      for (int n = 0; n < 10; n++) begin
         na = rand_bits(3) % 6 + 1;
         nb = rand_bits(3) % 6 + 1;
         run_case(na, nb, 0);
         check_results($sformatf("random run %0d", n));
      end
   endtask

   always @(negedge i_clk) begin
      if (!i_rst && o_out.valid) begin
         got_q.push_back(o_out.blk);
         if (o_out.blk.recs[0].key == '0) begin
            marks_seen++;
         end
      end
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < 200 * blocks_sent + 1000) begin
         @(posedge i_clk);
         cycle_cnt++;
      end
      $display("timeout: the DUT did not deliver all end markers in time");
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
   end

   initial begin
      i_rst = 1'b1;
      i_a = '0;
      i_b = '0;
      repeat (16) @(posedge i_clk);
      @(negedge i_clk);
      i_rst = 1'b0;
      test_single_blocks();
      test_interleaved();
      test_drain_paths();
      test_back_to_back();
      test_random_runs();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule
